//--- logic/ba_defines.svh
// ------------------------------------------------
// bus widths and target timing, two cores only
// MMIO is selected by one address bit, DRAM is word addressed
// ------------------------------------------------
`ifndef BA_DEFINES_SVH
`define BA_DEFINES_SVH

`define BA_ADDR_W        32
`define BA_DATA_W        32
`define BA_NCORE         2
`define BA_DRAM_WORDS    1024
`define BA_DRAM_LAT      4     // busy cycles per DRAM access
`define BA_MMIO_BASE_BIT 31

`endif

//--- logic/ba_pkg.sv
// ------------------------------------------------
// bus types shared by arbiter, config and targets
// ------------------------------------------------
`include "ba_defines.svh"

package ba_pkg;

    // byte address and data word
    typedef logic [`BA_ADDR_W-1:0] addr_t;
    typedef logic [`BA_DATA_W-1:0] data_t;

    typedef logic                  core_id_t;   // 1 bit, two cores
    typedef logic [`BA_NCORE-1:0]  core_mask_t;

    // config register index
    typedef logic [1:0]            cfg_addr_t;

    // arbiter sequence: capture, issue, wait, ack, release
    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_ISSUE,
        ARB_WAIT,
        ARB_ACK,
        ARB_RELEASE
    } arb_state_t;

endpackage

//--- logic/arb_config.sv
// ------------------------------------------------
// four-phase config port, grant counts read only and wrap
// ------------------------------------------------
`timescale 1ns/1ps
`include "ba_defines.svh"

module arb_config (
    input  logic                CLK,
    input  logic                RST_X,
    input  logic                cfg_req,
    input  logic                cfg_we,
    input  ba_pkg::cfg_addr_t   cfg_addr,
    input  ba_pkg::data_t       cfg_wdata,
    output logic                cfg_ack,
    output ba_pkg::data_t       cfg_rdata,
    input  logic                grant_valid,
    input  ba_pkg::core_id_t    grant_core,
    output logic                arb_mode,
    output ba_pkg::core_mask_t  core_enable
);

    ba_pkg::data_t grant_cnt [`BA_NCORE];
    ba_pkg::data_t rd_word;
    logic          cfg_start;

    // new request, ack not yet given
    assign cfg_start = cfg_req && !cfg_ack;

    always_comb begin
        case (cfg_addr)
            2'd0:    rd_word = ba_pkg::data_t'(arb_mode);
            2'd1:    rd_word = ba_pkg::data_t'(core_enable);
            2'd2:    rd_word = grant_cnt[0];
            default: rd_word = grant_cnt[1];
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            cfg_ack     <= 1'b0;
            arb_mode    <= 1'b0;       // fixed priority
            core_enable <= '1;
            for (int i = 0; i < `BA_NCORE; i++) begin
                grant_cnt[i] <= '0;
            end
        end else begin
            cfg_ack <= cfg_req;        // follows req by one cycle both ways
            if (cfg_start && cfg_we) begin
                case (cfg_addr)
                    2'd0:    arb_mode <= cfg_wdata[0];
                    2'd1:    core_enable <= cfg_wdata[`BA_NCORE-1:0];
                    default: ;         // counts are read only
                endcase
            end
            if (grant_valid) begin
                grant_cnt[grant_core] <= grant_cnt[grant_core] + 1'b1;
            end
        end
    end

    // read data held until the next request
    always_ff @(posedge CLK) begin
        if (cfg_start) begin
            cfg_rdata <= rd_word;
        end
    end

endmodule

//--- logic/bus_arbiter.sv
// ------------------------------------------------
// one access at a time, owner holds the bus until its req drops
// targets get a one-cycle strobe and answer with a busy level
// ------------------------------------------------
`timescale 1ns/1ps
`include "ba_defines.svh"

module bus_arbiter (
    input  logic                CLK,
    input  logic                RST_X,
    // core 0
    input  logic                req_0,
    input  logic                we_0,
    input  ba_pkg::addr_t       addr_0,
    input  ba_pkg::data_t       wdata_0,
    // core 1
    input  logic                req_1,
    input  logic                we_1,
    input  ba_pkg::addr_t       addr_1,
    input  ba_pkg::data_t       wdata_1,
    output logic                ack_0,
    output ba_pkg::data_t       rdata_0,
    output logic                ack_1,
    output ba_pkg::data_t       rdata_1,
    // config block
    input  logic                arb_mode,
    input  ba_pkg::core_mask_t  core_enable,
    output logic                grant_valid,
    output ba_pkg::core_id_t    grant_core,
    // targets
    output ba_pkg::addr_t       tgt_addr,
    output ba_pkg::data_t       tgt_wdata,
    output logic                dram_le,
    output logic                dram_we,
    output logic                mmio_le,
    output logic                mmio_we,
    input  logic                dram_busy,
    input  ba_pkg::data_t       dram_rdata,
    input  logic                mmio_busy,
    input  ba_pkg::data_t       mmio_rdata
);

    ba_pkg::arb_state_t state;
    ba_pkg::core_id_t   owner;      // also the last granted core
    ba_pkg::core_id_t   pick;
    ba_pkg::core_mask_t pend;
    logic               owner_req;
    logic               busy_seen;

    // captured request
    logic               r_we;
    ba_pkg::addr_t      r_addr;
    ba_pkg::data_t      r_wdata;
    ba_pkg::data_t      r_rdata;

    logic               r_mmio;
    logic               issue;
    logic               tgt_busy;
    ba_pkg::data_t      tgt_rdata;
    logic               capture;
    logic               done;

    always_comb begin
        pend = {req_1, req_0} & core_enable;
        if (pend == 2'b11) begin
            // tie: core 0 in fixed mode, else the one not granted last
            pick = arb_mode ? ~owner : 1'b0;
        end else begin
            pick = pend[1];
        end
    end

    assign capture   = (state == ba_pkg::ARB_IDLE) && (pend != '0);
    assign owner_req = owner ? req_1 : req_0;

    // target decode from the captured address
    assign r_mmio    = r_addr[`BA_MMIO_BASE_BIT];
    assign tgt_busy  = r_mmio ? mmio_busy : dram_busy;
    assign tgt_rdata = r_mmio ? mmio_rdata : dram_rdata;
    assign done      = (state == ba_pkg::ARB_WAIT) && busy_seen && !tgt_busy;

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            state     <= ba_pkg::ARB_IDLE;
            owner     <= 1'b1;          // so round robin starts with core 0
            busy_seen <= 1'b0;
        end else begin
            case (state)
                ba_pkg::ARB_IDLE: begin
                    if (capture) begin
                        owner <= pick;
                        state <= ba_pkg::ARB_ISSUE;
                    end
                end
                ba_pkg::ARB_ISSUE: begin
                    busy_seen <= 1'b0;
                    state     <= ba_pkg::ARB_WAIT;
                end
                ba_pkg::ARB_WAIT: begin
                    if (tgt_busy) begin
                        busy_seen <= 1'b1;
                    end else if (busy_seen) begin
                        state <= ba_pkg::ARB_ACK;
                    end
                end
                ba_pkg::ARB_ACK: begin
                    if (!owner_req) begin   // core has seen ack
                        state <= ba_pkg::ARB_RELEASE;
                    end
                end
                ba_pkg::ARB_RELEASE: begin
                    state <= ba_pkg::ARB_IDLE;
                end
                default: state <= ba_pkg::ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (capture) begin
            r_we    <= pick ? we_1 : we_0;
            r_addr  <= pick ? addr_1 : addr_0;
            r_wdata <= pick ? wdata_1 : wdata_0;
        end
        if (done) begin
            r_rdata <= r_we ? '0 : tgt_rdata;   // writes return zero
        end
    end

    // strobe lasts the single ISSUE cycle
    assign issue     = (state == ba_pkg::ARB_ISSUE);
    assign dram_le   = issue && !r_mmio && !r_we;
    assign dram_we   = issue && !r_mmio && r_we;
    assign mmio_le   = issue && r_mmio && !r_we;
    assign mmio_we   = issue && r_mmio && r_we;
    assign tgt_addr  = r_addr;
    assign tgt_wdata = r_wdata;

    assign grant_valid = issue;
    assign grant_core  = owner;

    assign ack_0   = (state == ba_pkg::ARB_ACK) && (owner == 1'b0);
    assign ack_1   = (state == ba_pkg::ARB_ACK) && (owner == 1'b1);
    assign rdata_0 = r_rdata;
    assign rdata_1 = r_rdata;

endmodule

//--- logic/dram_model.sv
// ------------------------------------------------
// fixed latency, one access in flight, contents not reset
// ------------------------------------------------
`timescale 1ns/1ps
`include "ba_defines.svh"

module dram_model (
    input  logic           CLK,
    input  logic           RST_X,
    input  logic           le,
    input  logic           we,
    input  ba_pkg::addr_t  addr,
    input  ba_pkg::data_t  wdata,
    output logic           busy,
    output ba_pkg::data_t  rdata
);

    localparam int AW = $clog2(`BA_DRAM_WORDS);
    localparam int CW = $clog2(`BA_DRAM_LAT + 1);

    ba_pkg::data_t   mem [`BA_DRAM_WORDS];
    logic [AW-1:0]   word_idx;
    logic [CW-1:0]   lat_cnt;

    assign word_idx = addr[AW+1:2];   // byte address to word

    // busy for BA_DRAM_LAT cycles after a strobe
    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            busy    <= 1'b0;
            lat_cnt <= '0;
        end else if (le || we) begin
            busy    <= 1'b1;
            lat_cnt <= CW'(`BA_DRAM_LAT - 1);
        end else if (busy) begin
            if (lat_cnt == '0) begin
                busy <= 1'b0;
            end else begin
                lat_cnt <= lat_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[word_idx] <= wdata;
        end
        if (le) begin
            rdata <= mem[word_idx];  // held until next read
        end
    end

endmodule

//--- logic/mmio_regs.sv
// ------------------------------------------------
// 4 scratch words, mtime at word 4 and 5, others read 0
// ------------------------------------------------
`timescale 1ns/1ps

module mmio_regs (
    input  logic           CLK,
    input  logic           RST_X,
    input  logic           le,
    input  logic           we,
    input  ba_pkg::addr_t  addr,
    input  ba_pkg::data_t  wdata,
    output logic           busy,
    output ba_pkg::data_t  rdata
);

    localparam int MTIME_W = 64;

    ba_pkg::data_t        scratch [4];
    logic [MTIME_W-1:0]   mtime;
    logic [2:0]           offset;
    ba_pkg::data_t        rd_word;

    assign offset = addr[4:2];

    always_comb begin
        case (offset)
            3'd0, 3'd1, 3'd2, 3'd3: rd_word = scratch[offset[1:0]];
            3'd4:    rd_word = mtime[31:0];
            3'd5:    rd_word = mtime[MTIME_W-1:32];
            default: rd_word = '0;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (!RST_X) begin
            busy  <= 1'b0;
            mtime <= '0;
            for (int i = 0; i < 4; i++) begin
                scratch[i] <= '0;
            end
        end else begin
            busy  <= le || we;          // single busy cycle
            mtime <= mtime + 1'b1;      // free running
            // mtime and unmapped words ignore writes
            if (we && !offset[2]) begin
                scratch[offset[1:0]] <= wdata;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (le) begin
            rdata <= rd_word;
        end
    end

endmodule

//--- logic/core_bus_top.sv
// ------------------------------------------------
// two cores and a config port onto DRAM and MMIO
// ------------------------------------------------
`timescale 1ns/1ps

module core_bus_top (
    input  logic               CLK,
    input  logic               RST_X,
    input  logic               req_0,
    input  logic               we_0,
    input  ba_pkg::addr_t      addr_0,
    input  ba_pkg::data_t      wdata_0,
    output logic               ack_0,
    output ba_pkg::data_t      rdata_0,
    input  logic               req_1,
    input  logic               we_1,
    input  ba_pkg::addr_t      addr_1,
    input  ba_pkg::data_t      wdata_1,
    output logic               ack_1,
    output ba_pkg::data_t      rdata_1,
    input  logic               cfg_req,
    input  logic               cfg_we,
    input  ba_pkg::cfg_addr_t  cfg_addr,
    input  ba_pkg::data_t      cfg_wdata,
    output logic               cfg_ack,
    output ba_pkg::data_t      cfg_rdata
);

    logic                arb_mode;
    ba_pkg::core_mask_t  core_enable;
    logic                grant_valid;
    ba_pkg::core_id_t    grant_core;

    // arbiter to target link
    ba_pkg::addr_t       tgt_addr;
    ba_pkg::data_t       tgt_wdata;
    logic                dram_le;
    logic                dram_we;
    logic                mmio_le;
    logic                mmio_we;
    logic                dram_busy;
    ba_pkg::data_t       dram_rdata;
    logic                mmio_busy;
    ba_pkg::data_t       mmio_rdata;

    bus_arbiter i_bus_arbiter (
        .CLK         (CLK),
        .RST_X       (RST_X),
        .req_0       (req_0),
        .we_0        (we_0),
        .addr_0      (addr_0),
        .wdata_0     (wdata_0),
        .req_1       (req_1),
        .we_1        (we_1),
        .addr_1      (addr_1),
        .wdata_1     (wdata_1),
        .ack_0       (ack_0),
        .rdata_0     (rdata_0),
        .ack_1       (ack_1),
        .rdata_1     (rdata_1),
        .arb_mode    (arb_mode),
        .core_enable (core_enable),
        .grant_valid (grant_valid),
        .grant_core  (grant_core),
        .tgt_addr    (tgt_addr),
        .tgt_wdata   (tgt_wdata),
        .dram_le     (dram_le),
        .dram_we     (dram_we),
        .mmio_le     (mmio_le),
        .mmio_we     (mmio_we),
        .dram_busy   (dram_busy),
        .dram_rdata  (dram_rdata),
        .mmio_busy   (mmio_busy),
        .mmio_rdata  (mmio_rdata)
    );

    arb_config i_arb_config (
        .CLK         (CLK),
        .RST_X       (RST_X),
        .cfg_req     (cfg_req),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .cfg_ack     (cfg_ack),
        .cfg_rdata   (cfg_rdata),
        .grant_valid (grant_valid),
        .grant_core  (grant_core),
        .arb_mode    (arb_mode),
        .core_enable (core_enable)
    );

    dram_model i_dram_model (
        .CLK   (CLK),
        .RST_X (RST_X),
        .le    (dram_le),
        .we    (dram_we),
        .addr  (tgt_addr),
        .wdata (tgt_wdata),
        .busy  (dram_busy),
        .rdata (dram_rdata)
    );

    mmio_regs i_mmio_regs (
        .CLK   (CLK),
        .RST_X (RST_X),
        .le    (mmio_le),
        .we    (mmio_we),
        .addr  (tgt_addr),
        .wdata (tgt_wdata),
        .busy  (mmio_busy),
        .rdata (mmio_rdata)
    );

endmodule

//--- tb/tb_core_bus.sv
// ------------------------------------------------
// DRAM reads only target words written earlier in the run
// ------------------------------------------------
`timescale 1ns/1ps
`include "ba_defines.svh"

module tb_core_bus;

    localparam int TMO = 200;   // cycles allowed per handshake phase
    localparam ba_pkg::addr_t MMIO = ba_pkg::addr_t'(1) << `BA_MMIO_BASE_BIT;

    logic                CLK;
    logic                RST_X;
    logic [1:0]          req;
    logic [1:0]          we;
    ba_pkg::addr_t       addr [2];
    ba_pkg::data_t       wdata [2];
    logic                ack_0;
    logic                ack_1;
    ba_pkg::data_t       rdata_0;
    ba_pkg::data_t       rdata_1;
    logic                cfg_req;
    logic                cfg_we;
    ba_pkg::cfg_addr_t   cfg_addr;
    ba_pkg::data_t       cfg_wdata;
    logic                cfg_ack;
    ba_pkg::data_t       cfg_rdata;

    int                  val_errs = 0;
    int                  proto_errs = 0;
    int                  tmo_errs = 0;
    logic [31:0]         rnd = 32'h95ec514e;
    ba_pkg::data_t       shadow [int];      // expected DRAM words
    ba_pkg::data_t       scratch [4];
    ba_pkg::data_t       done_cnt [2] = '{0, 0};
    int                  ack_order [$];
    int                  last_core = 1;

    core_bus_top i_core_bus_top (
        .CLK       (CLK),
        .RST_X     (RST_X),
        .req_0     (req[0]),
        .we_0      (we[0]),
        .addr_0    (addr[0]),
        .wdata_0   (wdata[0]),
        .ack_0     (ack_0),
        .rdata_0   (rdata_0),
        .req_1     (req[1]),
        .we_1      (we[1]),
        .addr_1    (addr[1]),
        .wdata_1   (wdata[1]),
        .ack_1     (ack_1),
        .rdata_1   (rdata_1),
        .cfg_req   (cfg_req),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_ack   (cfg_ack),
        .cfg_rdata (cfg_rdata)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    task automatic proto_fail(input string what);
        proto_errs++;
        $display("handshake rule broken at %0t: %s", $time, what);
    endtask

    // req sampled at the edge where ack went high
    assert property (@(posedge CLK) disable iff (!RST_X) $rose(ack_0) |-> $past(req[0]))
        else proto_fail("ack_0 rose without req_0");
    assert property (@(posedge CLK) disable iff (!RST_X) $rose(ack_1) |-> $past(req[1]))
        else proto_fail("ack_1 rose without req_1");
    assert property (@(posedge CLK) disable iff (!RST_X) $fell(ack_0) |-> !$past(req[0]))
        else proto_fail("ack_0 fell while req_0 was still high");
    assert property (@(posedge CLK) disable iff (!RST_X) $fell(ack_1) |-> !$past(req[1]))
        else proto_fail("ack_1 fell while req_1 was still high");
    assert property (@(posedge CLK) disable iff (!RST_X) !(ack_0 && ack_1))
        else proto_fail("ack_0 and ack_1 high together");
    assert property (@(posedge CLK) disable iff (!RST_X) $rose(cfg_ack) |-> $past(cfg_req))
        else proto_fail("cfg_ack rose without cfg_req");

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic ba_pkg::addr_t mmio_addr(input int off);
        return MMIO | (ba_pkg::addr_t'(off) << 2);
    endfunction

    task automatic check_val(input string name, input ba_pkg::data_t exp,
                             input ba_pkg::data_t act);
        assert (act === exp)
        else begin
            val_errs++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_rising(input string name, input ba_pkg::data_t prev,
                                input ba_pkg::data_t act);
        assert (act > prev)
        else begin
            val_errs++;
            $display("CHECK FAILED %s: expected above %h, actual %h", name, prev, act);
        end
    endtask

    // four-phase access from core c, called 1 ns after a rising edge
    task automatic bus_access(input int c, input logic w, input ba_pkg::addr_t a,
                              input ba_pkg::data_t d, input int tmo,
                              output ba_pkg::data_t rd);
        int n;
        we[c] = w;
        addr[c] = a;
        wdata[c] = d;
        req[c] = 1'b1;
        n = 0;
        while (!(c ? ack_1 : ack_0) && n < tmo) begin
            @(posedge CLK);
            #1;
            n++;
        end
        rd = c ? rdata_1 : rdata_0;
        if (c ? ack_1 : ack_0) begin
            ack_order.push_back(c);
            last_core = c;
            done_cnt[c]++;
        end else begin
            tmo_errs++;
            $display("core %0d got no ack within %0d cycles", c, tmo);
        end
        req[c] = 1'b0;
        n = 0;
        while ((c ? ack_1 : ack_0) && n < TMO) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (c ? ack_1 : ack_0) begin
            tmo_errs++;
            $display("core %0d ack stayed high after req fell", c);
        end
    endtask

    task automatic dram_op(input int c, input logic w, input int idx, input ba_pkg::data_t d);
        ba_pkg::data_t rd;
        bus_access(c, w, ba_pkg::addr_t'(idx) << 2, d, TMO, rd);
        if (w) begin
            shadow[idx] = d;
            check_val("dram write rdata", 0, rd);
        end else begin
            check_val("dram read", shadow[idx], rd);
        end
    endtask

    task automatic cfg_access(input logic w, input ba_pkg::cfg_addr_t a,
                              input ba_pkg::data_t d, output ba_pkg::data_t rd);
        int n;
        cfg_we = w;
        cfg_addr = a;
        cfg_wdata = d;
        cfg_req = 1'b1;
        n = 0;
        while (!cfg_ack && n < TMO) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (!cfg_ack) begin
            tmo_errs++;
            $display("config port got no ack for register %0d", a);
        end
        rd = cfg_rdata;
        cfg_req = 1'b0;
        n = 0;
        while (cfg_ack && n < TMO) begin
            @(posedge CLK);
            #1;
            n++;
        end
        if (cfg_ack) begin
            tmo_errs++;
            $display("cfg_ack stayed high after cfg_req fell");
        end
    endtask

    initial begin
        ba_pkg::data_t rd;
        ba_pkg::data_t rd1;
        ba_pkg::data_t prev;
        ba_pkg::data_t n1;
        int            idx;
        int            first;
        req = '0;
        we = '0;
        addr = '{0, 0};
        wdata = '{0, 0};
        cfg_req = 1'b0;
        cfg_we = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        RST_X = 1'b0;
        repeat (16) @(posedge CLK);
        #1;
        RST_X = 1'b1;
        @(posedge CLK);
        #1;
        check_val("outputs low after reset", 0, {ack_0, ack_1, cfg_ack});

        // write then read back from both cores
        dram_op(0, 1'b1, 5, 32'h1234_5678);
        dram_op(0, 1'b0, 5, 0);
        dram_op(1, 1'b0, 5, 0);
        dram_op(1, 1'b1, 9, 32'hcafe_0009);
        dram_op(0, 1'b0, 9, 0);
        for (int i = 0; i < 40; i++) begin
            rnd = xorshift(rnd);
            idx = rnd[5:0];
            if (rnd[8] && shadow.exists(idx)) begin
                dram_op(rnd[7], 1'b0, idx, 0);
            end else begin
                dram_op(rnd[7], 1'b1, idx, xorshift(rnd));
            end
        end

        // MMIO scratch, mtime and unmapped words
        for (int i = 0; i < 4; i++) begin
            rnd = xorshift(rnd);
            scratch[i] = rnd;
            bus_access(i % 2, 1'b1, mmio_addr(i), rnd, TMO, rd);
            check_val("mmio write rdata", 0, rd);
        end
        for (int i = 0; i < 4; i++) begin
            bus_access(1 - i % 2, 1'b0, mmio_addr(i), 0, TMO, rd);
            check_val("mmio scratch", scratch[i], rd);
        end
        bus_access(0, 1'b0, mmio_addr(4), 0, TMO, prev);
        bus_access(1, 1'b0, mmio_addr(4), 0, TMO, rd);
        check_rising("mtime low", prev, rd);
        prev = rd;
        bus_access(0, 1'b1, mmio_addr(4), 0, TMO, rd);   // mtime is read only
        bus_access(1, 1'b1, mmio_addr(6), 32'hdead_beef, TMO, rd);
        bus_access(1, 1'b0, mmio_addr(4), 0, TMO, rd);
        check_rising("mtime after write", prev, rd);
        bus_access(0, 1'b0, mmio_addr(6), 0, TMO, rd);
        check_val("mmio unmapped", 0, rd);
        bus_access(0, 1'b0, mmio_addr(2), 0, TMO, rd);
        check_val("mmio scratch after unmapped write", scratch[2], rd);

        // fixed priority
        cfg_access(1'b1, 2'd0, 0, rd);
        ack_order.delete();
        fork
            dram_op(0, 1'b1, 100, 32'h0000_a100);
            dram_op(1, 1'b1, 200, 32'h0000_b200);
        join
        check_val("fixed priority first ack", 0, ack_order[0]);

        // round robin under steady contention
        cfg_access(1'b1, 2'd0, 1, rd);
        first = 1 - last_core;
        ack_order.delete();
        fork
            for (int i = 0; i < 3; i++) begin
                dram_op(0, 1'b1, 110 + i, 32'h0000_c000 + i);
            end
            for (int i = 0; i < 3; i++) begin
                dram_op(1, 1'b1, 210 + i, 32'h0000_d000 + i);
            end
        join
        for (int i = 0; i < 6; i++) begin
            check_val("round robin order", (first + i) % 2, ack_order[i]);
        end

        // core 1 masked while core 0 works
        cfg_access(1'b1, 2'd1, 32'h1, rd);
        n1 = done_cnt[1];
        fork
            bus_access(1, 1'b0, ba_pkg::addr_t'(200) << 2, 0, 4 * TMO, rd1);
            begin
                for (int i = 0; i < 3; i++) begin
                    dram_op(0, 1'b0, 100, 0);
                end
                repeat (TMO) @(posedge CLK);
                #1;
                check_val("masked core completions", n1, done_cnt[1]);
                cfg_access(1'b1, 2'd1, 32'h3, rd);
            end
        join
        check_val("unmasked core read", shadow[200], rd1);

        // grant counters match completions and ignore writes
        for (int c = 0; c < 2; c++) begin
            cfg_access(1'b0, ba_pkg::cfg_addr_t'(2 + c), 0, rd);
            check_val("grant count", done_cnt[c], rd);
            cfg_access(1'b1, ba_pkg::cfg_addr_t'(2 + c), 32'h5a5a_0000, rd);
            cfg_access(1'b0, ba_pkg::cfg_addr_t'(2 + c), 0, rd);
            check_val("grant count after write", done_cnt[c], rd);
        end

        $display("errors: value %0d, handshake %0d, timeout %0d",
                 val_errs, proto_errs, tmo_errs);
        if (val_errs + proto_errs + tmo_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // overall limit on run length
    initial begin
        repeat (100000) @(posedge CLK);
        $display("simulation ran past its cycle limit");
        $display("Test failures found");
        $finish;
    end

endmodule

//--- flist.f
+incdir+logic
logic/ba_pkg.sv
logic/arb_config.sv
logic/bus_arbiter.sv
logic/dram_model.sv
logic/mmio_regs.sv
logic/core_bus_top.sv
tb/tb_core_bus.sv
